//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module rv_pipeline_tb \
  -f rv_pipeline.f -o rv_pipeline_sim &&
  out="$(./obj_dir/rv_pipeline_sim)" || { echo "$out"; echo "build or run failed"; exit 1; }
echo "$out"
echo "$out" | grep -qx "TEST OK" && exit 0 || exit 1

//--- rv_pipeline.f
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/regfile.sv
source/fetch_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/retire_stage.sv
source/rv_pipeline_top.sv
test/clock_gen.sv
test/rv_pipeline_chk.sv
test/rv_pipeline_tb.sv

//--- source/decode_stage.sv
module decode_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  pipe_pkg::stage_t     d_slot_i,
  input  logic                 redirect_i,
  input  rv_isa_pkg::word_t    rs1_data_i,
  input  rv_isa_pkg::word_t    rs2_data_i,
  output rv_isa_pkg::reg_idx_t rs1_o,
  output rv_isa_pkg::reg_idx_t rs2_o,
  output pipe_pkg::stage_t     x_slot_o,
  output rv_isa_pkg::word_t    x_rs1_o,
  output rv_isa_pkg::word_t    x_rs2_o
);

  rv_isa_pkg::r_fmt_t r;
  logic               illegal;

  assign r     = d_slot_i.insn.r_fmt;
  assign rs1_o = r.rs1;
  assign rs2_o = r.rs2;

  always_comb begin
    illegal = 1'b0;
    case (r.opcode)
      rv_isa_pkg::op_lui: begin
        illegal = 1'b0;
      end
      rv_isa_pkg::op_reg_imm: begin
        // shift immediates carry funct7 in the upper bits
        if (r.funct3 == rv_isa_pkg::f3_sll) begin
          illegal = r.funct7 != rv_isa_pkg::f7_base;
        end else if (r.funct3 == rv_isa_pkg::f3_sr) begin
          illegal = r.funct7 != rv_isa_pkg::f7_base && r.funct7 != rv_isa_pkg::f7_alt;
        end
      end
      rv_isa_pkg::op_reg_reg: begin
        if (r.funct7 == rv_isa_pkg::f7_alt) begin
          illegal = r.funct3 != rv_isa_pkg::f3_add && r.funct3 != rv_isa_pkg::f3_sr;
        end else if (r.funct7 == rv_isa_pkg::f7_muldiv) begin
          illegal = !(r.funct3 inside {rv_isa_pkg::f3_mul, rv_isa_pkg::f3_mulh,
                                       rv_isa_pkg::f3_mulhsu, rv_isa_pkg::f3_mulhu});
        end else begin
          illegal = r.funct7 != rv_isa_pkg::f7_base;
        end
      end
      rv_isa_pkg::op_branch: begin
        illegal = !(r.funct3 inside {rv_isa_pkg::f3_beq, rv_isa_pkg::f3_bne,
                                     rv_isa_pkg::f3_blt, rv_isa_pkg::f3_bge,
                                     rv_isa_pkg::f3_bltu, rv_isa_pkg::f3_bgeu});
      end
      rv_isa_pkg::op_environ: begin
        // only ecall, everything above the opcode zero
        illegal = {r.funct7, r.rs2, r.rs1, r.funct3, r.rd} != '0;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      x_slot_o <= '{pc: '0, insn: '0, status: pipe_pkg::cs_reset, result: '0};
    end else begin
      x_slot_o.pc     <= d_slot_i.pc;
      x_slot_o.insn   <= d_slot_i.insn;
      x_slot_o.result <= '0;
      // a flush wins over the legality check
      if (redirect_i) begin
        x_slot_o.status <= pipe_pkg::cs_taken_branch;
      end else if (d_slot_i.status == pipe_pkg::cs_no_stall && illegal) begin
        x_slot_o.status <= pipe_pkg::cs_invalid;
      end else begin
        x_slot_o.status <= d_slot_i.status;
      end
    end
  end

  always_ff @(posedge clk) begin
    x_rs1_o <= rs1_data_i;
    x_rs2_o <= rs2_data_i;
  end

endmodule

//--- source/execute_stage.sv
module execute_stage (
  input  logic              clk,
  input  logic              rst,
  input  pipe_pkg::stage_t  x_slot_i,
  input  rv_isa_pkg::word_t x_rs1_i,
  input  rv_isa_pkg::word_t x_rs2_i,
  input  pipe_pkg::stage_t  w_slot_i,
  output logic              redirect_o,
  output rv_isa_pkg::word_t target_o,
  output pipe_pkg::stage_t  m_slot_o
);

  pipe_pkg::stage_t   m_slot;
  rv_isa_pkg::r_fmt_t r;
  rv_isa_pkg::i_fmt_t i;
  rv_isa_pkg::b_fmt_t b;

  rv_isa_pkg::word_t  op_a;
  rv_isa_pkg::word_t  op_b;
  rv_isa_pkg::word_t  imm_i;
  rv_isa_pkg::word_t  imm_b;
  rv_isa_pkg::word_t  rhs;
  logic [4:0]         shamt;
  rv_isa_pkg::word_t  alu_res;
  rv_isa_pkg::word_t  mul_res;
  rv_isa_pkg::word_t  result;
  logic [32:0]        mul_a;
  logic [32:0]        mul_b;
  logic signed [65:0] product;
  logic               take;

  // true when the slot will write a nonzero rd
  function automatic logic is_bypass_src(pipe_pkg::stage_t s);
    logic [6:0] opc;
    opc = s.insn.r_fmt.opcode;
    return s.status == pipe_pkg::cs_no_stall && s.insn.r_fmt.rd != '0 &&
           (opc == rv_isa_pkg::op_lui || opc == rv_isa_pkg::op_reg_imm ||
            opc == rv_isa_pkg::op_reg_reg);
  endfunction

  // youngest producer first
  function automatic rv_isa_pkg::word_t fwd(rv_isa_pkg::reg_idx_t src,
                                            rv_isa_pkg::word_t reg_val,
                                            pipe_pkg::stage_t m, pipe_pkg::stage_t w);
    if (is_bypass_src(m) && m.insn.r_fmt.rd == src) begin
      return m.result;
    end else if (is_bypass_src(w) && w.insn.r_fmt.rd == src) begin
      return w.result;
    end
    return reg_val;
  endfunction

  assign r = x_slot_i.insn.r_fmt;
  assign i = x_slot_i.insn.i_fmt;
  assign b = x_slot_i.insn.b_fmt;

  assign op_a = fwd(r.rs1, x_rs1_i, m_slot, w_slot_i);
  assign op_b = fwd(r.rs2, x_rs2_i, m_slot, w_slot_i);

  assign imm_i = {{20{i.imm12[11]}}, i.imm12};
  assign imm_b = {{20{b.imm_hi7[6]}}, b.imm_lo5[0], b.imm_hi7[5:0], b.imm_lo5[4:1], 1'b0};

  assign rhs   = (r.opcode == rv_isa_pkg::op_reg_reg) ? op_b : imm_i;
  assign shamt = rhs[4:0];

  always_comb begin
    case (r.funct3)
      rv_isa_pkg::f3_add: begin
        if (r.opcode == rv_isa_pkg::op_reg_reg && r.funct7 == rv_isa_pkg::f7_alt) begin
          alu_res = op_a - rhs;
        end else begin
          alu_res = op_a + rhs;
        end
      end
      rv_isa_pkg::f3_sll:  alu_res = op_a << shamt;
      rv_isa_pkg::f3_slt:  alu_res = {31'b0, $signed(op_a) < $signed(rhs)};
      rv_isa_pkg::f3_sltu: alu_res = {31'b0, op_a < rhs};
      rv_isa_pkg::f3_xor:  alu_res = op_a ^ rhs;
      rv_isa_pkg::f3_sr: begin
        // srai has the alt funct7 in its immediate too
        if (r.funct7 == rv_isa_pkg::f7_alt) begin
          alu_res = rv_isa_pkg::word_t'($signed(op_a) >>> shamt);
        end else begin
          alu_res = op_a >> shamt;
        end
      end
      rv_isa_pkg::f3_or:   alu_res = op_a | rhs;
      default:             alu_res = op_a & rhs;
    endcase
  end

  // one 33x33 signed multiplier covers all four variants
  assign mul_a   = {(r.funct3 == rv_isa_pkg::f3_mulh || r.funct3 == rv_isa_pkg::f3_mulhsu)
                    & op_a[31], op_a};
  assign mul_b   = {(r.funct3 == rv_isa_pkg::f3_mulh) & op_b[31], op_b};
  assign product = $signed(mul_a) * $signed(mul_b);
  assign mul_res = (r.funct3 == rv_isa_pkg::f3_mul) ? product[31:0] : product[63:32];

  always_comb begin
    case (r.opcode)
      rv_isa_pkg::op_lui:     result = {i.imm12, i.rs1, i.funct3, 12'b0};
      rv_isa_pkg::op_reg_imm: result = alu_res;
      rv_isa_pkg::op_reg_reg: begin
        result = (r.funct7 == rv_isa_pkg::f7_muldiv) ? mul_res : alu_res;
      end
      default:                result = '0;
    endcase
  end

  always_comb begin
    case (b.funct3)
      rv_isa_pkg::f3_beq:  take = op_a == op_b;
      rv_isa_pkg::f3_bne:  take = op_a != op_b;
      rv_isa_pkg::f3_blt:  take = $signed(op_a) < $signed(op_b);
      rv_isa_pkg::f3_bge:  take = $signed(op_a) >= $signed(op_b);
      rv_isa_pkg::f3_bltu: take = op_a < op_b;
      rv_isa_pkg::f3_bgeu: take = op_a >= op_b;
      default:             take = 1'b0;
    endcase
  end

  assign redirect_o = x_slot_i.status == pipe_pkg::cs_no_stall &&
                      b.opcode == rv_isa_pkg::op_branch && take;
  assign target_o   = x_slot_i.pc + imm_b;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_slot <= '{pc: '0, insn: '0, status: pipe_pkg::cs_reset, result: '0};
    end else begin
      m_slot.pc     <= x_slot_i.pc;
      m_slot.insn   <= x_slot_i.insn;
      m_slot.status <= x_slot_i.status;
      m_slot.result <= result;
    end
  end

  assign m_slot_o = m_slot;

endmodule

//--- source/fetch_unit.sv
module fetch_unit (
  input  logic               clk,
  input  logic               rst,
  input  pipe_pkg::prog_wr_t prog_i,
  input  logic               start_i,
  input  logic               redirect_i,
  input  rv_isa_pkg::word_t  target_i,
  output pipe_pkg::stage_t   d_slot_o
);

  rv_isa_pkg::word_t imem [pipe_pkg::imem_words];

  logic                 run;
  rv_isa_pkg::word_t    pc;
  pipe_pkg::imem_addr_t fetch_addr;
  rv_isa_pkg::word_t    fetch_word;

  // program load port
  always_ff @(posedge clk) begin
    if (prog_i.we) begin
      imem[prog_i.addr] <= prog_i.data;
    end
  end

  assign fetch_addr = pc[2 +: $bits(pipe_pkg::imem_addr_t)];
  assign fetch_word = imem[fetch_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      run <= 1'b0;
      pc  <= '0;
    end else begin
      if (start_i) begin
        run <= 1'b1;
      end
      // pc holds while idle
      if (run) begin
        pc <= redirect_i ? target_i : pc + 32'd4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !run) begin
      d_slot_o <= '{pc: '0, insn: '0, status: pipe_pkg::cs_reset, result: '0};
    end else begin
      d_slot_o.pc     <= pc;
      d_slot_o.insn   <= fetch_word;
      d_slot_o.status <= redirect_i ? pipe_pkg::cs_taken_branch : pipe_pkg::cs_no_stall;
      d_slot_o.result <= '0;
    end
  end

endmodule

//--- source/pipe_pkg.sv
package pipe_pkg;

  localparam int imem_words = 256;

  typedef logic [$clog2(imem_words)-1:0] imem_addr_t;

  // what occupies a slot as it reaches writeback
  typedef enum logic [2:0] {
    cs_invalid      = 3'd0,
    cs_reset        = 3'd1,
    cs_no_stall     = 3'd2,
    cs_taken_branch = 3'd4
  } cycle_status_e;

  typedef struct packed {
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::insn_u insn;
    cycle_status_e     status;
    rv_isa_pkg::word_t result;
  } stage_t;

  // program load strobe, one word per cycle
  typedef struct packed {
    logic              we;
    imem_addr_t        addr;
    rv_isa_pkg::word_t data;
  } prog_wr_t;

  typedef struct packed {
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::insn_u    insn;
    cycle_status_e        status;
    logic                 rf_we;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    rd_data;
  } trace_t;

  typedef struct packed {
    logic                 we;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    data;
  } rf_wr_t;

endpackage

//--- source/regfile.sv
module regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  pipe_pkg::rf_wr_t     wr_i,
  input  rv_isa_pkg::reg_idx_t rs1_i,
  input  rv_isa_pkg::reg_idx_t rs2_i,
  output rv_isa_pkg::word_t    rs1_data_o,
  output rv_isa_pkg::word_t    rs2_data_o
);

  // x0 has no storage
  rv_isa_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_i.we && wr_i.rd != '0) begin
      regs[wr_i.rd] <= wr_i.data;
    end
  end

  // same-cycle write is visible to decode
  always_comb begin
    if (rs1_i == '0) begin
      rs1_data_o = '0;
    end else if (wr_i.we && wr_i.rd == rs1_i) begin
      rs1_data_o = wr_i.data;
    end else begin
      rs1_data_o = regs[rs1_i];
    end
    if (rs2_i == '0) begin
      rs2_data_o = '0;
    end else if (wr_i.we && wr_i.rd == rs2_i) begin
      rs2_data_o = wr_i.data;
    end else begin
      rs2_data_o = regs[rs2_i];
    end
  end

endmodule

//--- source/retire_stage.sv
module retire_stage (
  input  logic             clk,
  input  logic             rst,
  input  pipe_pkg::stage_t m_slot_i,
  output pipe_pkg::stage_t w_slot_o,
  output pipe_pkg::rf_wr_t rf_wr_o,
  output logic             halt_o,
  output pipe_pkg::trace_t trace_o
);

  logic       flushed;
  logic       no_stall;
  logic [6:0] opc;

  assign flushed = m_slot_i.status == pipe_pkg::cs_taken_branch;

  always_ff @(posedge clk) begin
    if (rst) begin
      w_slot_o <= '{pc: '0, insn: '0, status: pipe_pkg::cs_reset, result: '0};
    end else begin
      // flushed slots retire with pc and insn cleared
      w_slot_o.pc     <= flushed ? '0 : m_slot_i.pc;
      w_slot_o.insn   <= flushed ? '0 : m_slot_i.insn;
      w_slot_o.status <= m_slot_i.status;
      w_slot_o.result <= m_slot_i.result;
    end
  end

  assign no_stall = w_slot_o.status == pipe_pkg::cs_no_stall;
  assign opc      = w_slot_o.insn.r_fmt.opcode;

  // decode has already checked the ecall encoding
  always_ff @(posedge clk) begin
    if (rst) begin
      halt_o <= 1'b0;
    end else if (no_stall && opc == rv_isa_pkg::op_environ) begin
      halt_o <= 1'b1;
    end
  end

  assign rf_wr_o.we   = no_stall && !halt_o && w_slot_o.insn.r_fmt.rd != '0 &&
                        (opc == rv_isa_pkg::op_lui || opc == rv_isa_pkg::op_reg_imm ||
                         opc == rv_isa_pkg::op_reg_reg);
  assign rf_wr_o.rd   = w_slot_o.insn.r_fmt.rd;
  assign rf_wr_o.data = w_slot_o.result;

  always_comb begin
    trace_o.pc      = w_slot_o.pc;
    trace_o.insn    = w_slot_o.insn;
    trace_o.status  = w_slot_o.status;
    trace_o.rf_we   = rf_wr_o.we;
    trace_o.rd      = rf_wr_o.rd;
    trace_o.rd_data = rf_wr_o.data;
  end

endmodule

//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes handled by the core
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_environ = 7'b1110011;

  localparam logic [6:0] f7_base   = 7'b0000000;
  localparam logic [6:0] f7_alt    = 7'b0100000;
  localparam logic [6:0] f7_muldiv = 7'b0000001;

  // alu funct3, shared by reg-imm and reg-reg
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // multiply funct3 under f7_muldiv
  localparam logic [2:0] f3_mul    = 3'b000;
  localparam logic [2:0] f3_mulh   = 3'b001;
  localparam logic [2:0] f3_mulhsu = 3'b010;
  localparam logic [2:0] f3_mulhu  = 3'b011;

  // conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo5;
    logic [6:0] opcode;
  } b_fmt_t;

  // one instruction word, seen through the format in use
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
  } insn_u;

endpackage

//--- source/rv_pipeline_top.sv
module rv_pipeline_top (
  input  logic               clk,
  input  logic               rst,
  input  pipe_pkg::prog_wr_t prog_i,
  input  logic               start_i,
  output logic               halt_o,
  output pipe_pkg::trace_t   trace_o
);

  pipe_pkg::stage_t     d_slot;
  pipe_pkg::stage_t     x_slot;
  pipe_pkg::stage_t     m_slot;
  pipe_pkg::stage_t     w_slot;
  pipe_pkg::rf_wr_t     rf_wr;
  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rs2;
  rv_isa_pkg::word_t    rs1_data;
  rv_isa_pkg::word_t    rs2_data;
  rv_isa_pkg::word_t    x_rs1;
  rv_isa_pkg::word_t    x_rs2;
  logic                 redirect;
  rv_isa_pkg::word_t    target;

  fetch_unit u_fetch (
    .clk        (clk),
    .rst        (rst),
    .prog_i     (prog_i),
    .start_i    (start_i),
    .redirect_i (redirect),
    .target_i   (target),
    .d_slot_o   (d_slot)
  );

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .d_slot_i   (d_slot),
    .redirect_i (redirect),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .x_slot_o   (x_slot),
    .x_rs1_o    (x_rs1),
    .x_rs2_o    (x_rs2)
  );

  execute_stage u_execute (
    .clk        (clk),
    .rst        (rst),
    .x_slot_i   (x_slot),
    .x_rs1_i    (x_rs1),
    .x_rs2_i    (x_rs2),
    .w_slot_i   (w_slot),
    .redirect_o (redirect),
    .target_o   (target),
    .m_slot_o   (m_slot)
  );

  retire_stage u_retire (
    .clk      (clk),
    .rst      (rst),
    .m_slot_i (m_slot),
    .w_slot_o (w_slot),
    .rf_wr_o  (rf_wr),
    .halt_o   (halt_o),
    .trace_o  (trace_o)
  );

  regfile u_rf (
    .clk        (clk),
    .rst        (rst),
    .wr_i       (rf_wr),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

endmodule

//--- test/clock_gen.sv
module clock_gen #(
  parameter int period = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(period / 2) clk_o = ~clk_o;

endmodule

//--- test/rv_pipeline_chk.sv
module rv_pipeline_chk (
  input logic             clk,
  input logic             rst,
  input logic             halt_o,
  input pipe_pkg::trace_t trace_o
);

  // halt is sticky until reset
  halt_sticky: assert property (@(posedge clk) halt_o && !rst |=> halt_o || rst)
    else $error("halt_o fell without reset");

  // only real instructions write, and never x0
  write_legal: assert property (@(posedge clk) disable iff (rst)
    trace_o.rf_we |-> trace_o.status == pipe_pkg::cs_no_stall && trace_o.rd != '0)
    else $error("trace write from a non-retiring slot or to x0");

  flush_zeroed: assert property (@(posedge clk) disable iff (rst)
    trace_o.status == pipe_pkg::cs_taken_branch |-> trace_o.pc == '0 && trace_o.insn == '0)
    else $error("flushed slot retired with nonzero pc or insn");

endmodule

bind rv_pipeline_top rv_pipeline_chk u_chk (
  .clk     (clk),
  .rst     (rst),
  .halt_o  (halt_o),
  .trace_o (trace_o)
);

//--- test/rv_pipeline_tb.sv
module rv_pipeline_tb;

  localparam int n_progs = 6;
  localparam int max_len = 64;
  localparam logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  logic               clk;
  logic               rst;
  logic               start_i;
  logic               halt_o;
  pipe_pkg::prog_wr_t prog_i;
  pipe_pkg::trace_t   trace_o;

  logic [31:0]       lfsr_state = 32'h1a2a8b92;
  rv_isa_pkg::word_t prog [max_len];
  logic              illegal_w [max_len];
  rv_isa_pkg::word_t regs [32];
  int                n_insn;
  int                checks = 0;
  int                value_errors = 0;
  int                other_errors = 0;

  clock_gen #(.period(40)) u_clk (.clk_o(clk));

  rv_pipeline_top dut (
    .clk     (clk),
    .rst     (rst),
    .prog_i  (prog_i),
    .start_i (start_i),
    .halt_o  (halt_o),
    .trace_o (trace_o)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic int rand_below(int m);
    return int'(rand_bits(16) % m);
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      value_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_counts();
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
  endtask

  task automatic note_failure(string why);
    other_errors++;
    $display("%s", why);
  endtask

  task automatic make_program();
    logic [31:0] rnd;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [12:0] off;
    n_insn = 40 + rand_below(21);
    for (int j = 0; j < n_insn; j++) begin
      // x0..x7 only, so hazards are common
      rd  = 5'(rand_bits(3));
      rs1 = 5'(rand_bits(3));
      rs2 = 5'(rand_bits(3));
      f3  = 3'(rand_bits(3));
      illegal_w[j] = 1'b0;
      if (rand_below(20) == 0) begin
        rnd = rand_bits(25);
        prog[j] = {rnd[24:0], 7'b0000011};
        illegal_w[j] = 1'b1;
      end else begin
        case (rand_bits(2))
          2'd0: begin
            rnd = rand_bits(20);
            prog[j] = {rnd[19:0], rd, 7'b0110111};
          end
          2'd1: begin
            rnd = rand_bits(12);
            if (f3 == 3'b001) begin
              rnd[11:5] = 7'b0;
            end else if (f3 == 3'b101) begin
              rnd[11:5] = rnd[11] ? 7'b0100000 : 7'b0;
            end
            prog[j] = {rnd[11:0], rs1, f3, rd, 7'b0010011};
          end
          2'd2: begin
            if (rand_bits(2) == 0) begin
              f7 = 7'b0000001;
              f3 = {1'b0, f3[1:0]};
            end else if ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) == 1) begin
              f7 = 7'b0100000;
            end else begin
              f7 = 7'b0;
            end
            prog[j] = {f7, rs2, rs1, f3, rd, 7'b0110011};
          end
          default: begin
            // forward only, landing at or before the ecall
            f3  = br_f3[rand_below(6)];
            off = 13'((1 + rand_below(n_insn - j)) * 4);
            prog[j] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
          end
        endcase
      end
    end
    prog[n_insn]      = 32'h00000073;
    illegal_w[n_insn] = 1'b0;
  endtask

  function automatic logic [31:0] alu_ref(logic [31:0] a, logic [31:0] b, logic [2:0] f3,
                                          logic sub, logic arith);
    case (f3)
      3'd0: return sub ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return arith ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // architectural step of one legal instruction
  task automatic model_exec(input rv_isa_pkg::word_t w, input int idx, output logic we,
                            output logic [31:0] res, output int nxt, output logic taken);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] p;
    logic [12:0] boff;
    logic        cond;
    a     = regs[w[19:15]];
    b     = regs[w[24:20]];
    imm   = {{20{w[31]}}, w[31:20]};
    sa    = {{32{a[31]}}, a};
    ua    = {32'b0, a};
    sb    = {{32{b[31]}}, b};
    ub    = {32'b0, b};
    we    = 1'b0;
    res   = '0;
    nxt   = idx + 1;
    taken = 1'b0;
    cond  = 1'b0;
    case (w[6:0])
      7'b0110111: begin
        we  = 1'b1;
        res = {w[31:12], 12'b0};
      end
      7'b0010011: begin
        we  = 1'b1;
        res = alu_ref(a, imm, w[14:12], 1'b0, w[30]);
      end
      7'b0110011: begin
        we = 1'b1;
        if (w[31:25] == 7'b0000001) begin
          case (w[13:12])
            2'd0: p = ua * ub;
            2'd1: p = sa * sb;
            2'd2: p = sa * ub;
            default: p = ua * ub;
          endcase
          res = (w[13:12] == 2'd0) ? p[31:0] : p[63:32];
        end else begin
          res = alu_ref(a, b, w[14:12], w[30], w[30]);
        end
      end
      7'b1100011: begin
        case (w[14:12])
          3'd0: cond = a == b;
          3'd1: cond = a != b;
          3'd4: cond = $signed(a) < $signed(b);
          3'd5: cond = $signed(a) >= $signed(b);
          3'd6: cond = a < b;
          default: cond = a >= b;
        endcase
        boff = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        if (cond) begin
          taken = 1'b1;
          nxt   = idx + int'($signed(boff)) / 4;
        end
      end
      default: begin
        we = 1'b0;
      end
    endcase
    if (we && w[11:7] != 5'd0) begin
      regs[w[11:7]] = res;
    end else begin
      we = 1'b0;
    end
  endtask

  task automatic load_and_start(int p);
    rv_isa_pkg::word_t data;
    @(posedge clk);
    rst       <= 1'b1;
    start_i   <= 1'b0;
    prog_i.we <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int a = 0; a < pipe_pkg::imem_words; a++) begin
      // filler is lui x5 with the whole address in its immediate
      data = (a <= n_insn) ? prog[a] : {8'(a), ~8'(a), 4'h0, 5'd5, 7'b0110111};
      @(posedge clk);
      prog_i <= '{we: 1'b1, addr: pipe_pkg::imem_addr_t'(a), data: data};
      @(negedge clk);
      check_value($sformatf("prog %0d idle status", p), pipe_pkg::cs_reset, trace_o.status);
      check_value($sformatf("prog %0d idle rf_we", p), 1'b0, trace_o.rf_we);
    end
    @(posedge clk);
    prog_i.we <= 1'b0;
    start_i   <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
  endtask

  task automatic run_program(int p);
    int          mpc;
    int          flush_left;
    int          cycles;
    int          nxt;
    logic        done;
    logic        retired_any;
    logic        we;
    logic        taken;
    logic [31:0] res;
    mpc         = 0;
    flush_left  = 0;
    cycles      = 0;
    done        = 1'b0;
    retired_any = 1'b0;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (cycles > 1000) begin
        note_failure($sformatf("timeout: program %0d never retired its ecall", p));
        return;
      end
      if (mpc > n_insn) begin
        note_failure($sformatf("model of program %0d ran past the ecall", p));
        return;
      end
      // halt only follows the ecall leaving writeback
      check_value($sformatf("prog %0d halt early", p), 1'b0, halt_o);
      if (!retired_any && trace_o.status == pipe_pkg::cs_reset) begin
        check_value($sformatf("prog %0d startup rf_we", p), 1'b0, trace_o.rf_we);
      end else if (flush_left > 0) begin
        check_value($sformatf("prog %0d flush status", p), pipe_pkg::cs_taken_branch,
                    trace_o.status);
        check_value($sformatf("prog %0d flush pc", p), '0, trace_o.pc);
        check_value($sformatf("prog %0d flush insn", p), '0, trace_o.insn);
        check_value($sformatf("prog %0d flush rf_we", p), 1'b0, trace_o.rf_we);
        flush_left--;
      end else begin
        retired_any = 1'b1;
        check_value($sformatf("prog %0d idx %0d pc", p, mpc), mpc * 4, trace_o.pc);
        check_value($sformatf("prog %0d idx %0d insn", p, mpc), prog[mpc], trace_o.insn);
        if (illegal_w[mpc]) begin
          check_value($sformatf("prog %0d idx %0d status", p, mpc), pipe_pkg::cs_invalid,
                      trace_o.status);
          check_value($sformatf("prog %0d idx %0d rf_we", p, mpc), 1'b0, trace_o.rf_we);
          mpc++;
        end else begin
          check_value($sformatf("prog %0d idx %0d status", p, mpc), pipe_pkg::cs_no_stall,
                      trace_o.status);
          model_exec(prog[mpc], mpc, we, res, nxt, taken);
          check_value($sformatf("prog %0d idx %0d rf_we", p, mpc), we, trace_o.rf_we);
          if (we) begin
            check_value($sformatf("prog %0d idx %0d rd", p, mpc), prog[mpc][11:7], trace_o.rd);
            check_value($sformatf("prog %0d idx %0d rd_data", p, mpc), res, trace_o.rd_data);
          end
          done       = prog[mpc] == 32'h00000073;
          flush_left = taken ? 2 : 0;
          mpc        = nxt;
        end
      end
    end
    cycles = 0;
    while (halt_o !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 5) begin
        note_failure($sformatf("halt_o did not rise after the ecall of program %0d", p));
        return;
      end
    end
    // nothing may write once halted
    repeat (12) begin
      @(negedge clk);
      check_value($sformatf("prog %0d halt held", p), 1'b1, halt_o);
      check_value($sformatf("prog %0d write after halt", p), 1'b0, trace_o.rf_we);
    end
  endtask

  initial begin
    rst     <= 1'b1;
    start_i <= 1'b0;
    prog_i  <= '0;
    for (int p = 0; p < n_progs && other_errors == 0; p++) begin
      make_program();
      load_and_start(p);
      run_program(p);
    end
    report_counts();
    if (value_errors + other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
